//--- hw/spi_reg_bridge_pkg.sv
`default_nettype none

package spi_reg_bridge_pkg;

  // data byte width, low part of every frame
  localparam int DATA_W = 8;

  // default frame length, address byte plus data byte
  localparam int FRAME_BITS_DEF = 16;

  // default address width for a 16 bit frame
  localparam int ADDR_W_DEF = FRAME_BITS_DEF - DATA_W;

  // downstream adc chip selects behind the router
  localparam int NUM_ADC_CS_DEF = 4;

  // recognised register addresses
  // anything else on the bus is dropped
  typedef enum logic [ADDR_W_DEF-1:0] {
    ADDR_LED = 8'd7,
    ADDR_MUX = 8'd8
  } reg_addr_e;

  // frame controller states
  // idle waits for ss_n low, shift counts bits, close judges the frame
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SHIFT = 2'd1,
    CLOSE = 2'd2
  } frame_state_e;

endpackage

`default_nettype wire

//--- hw/spi_pin_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync (
  input  logic cs,
  input  logic rst_n,
  input  logic sclk,
  input  logic ss_n,
  input  logic mosi,
  input  logic special,
  output logic sclk_fall,
  output logic ss_fall,
  output logic ss_rise,
  output logic ss_lvl,
  output logic mosi_s,
  output logic special_s
);

  // first and second synchroniser stages per pin
  logic sclk_m, sclk_s;
  logic ss_m, ss_s;
  logic mosi_m, mosi_q;
  logic special_m, special_q;

  // previous sclk level for edge detection
  logic sclk_d;

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      // idle bus levels, so no edge pops out of reset
      sclk_m    <= 1'b0;
      sclk_s    <= 1'b0;
      sclk_d    <= 1'b0;
      ss_m      <= 1'b1;
      ss_s      <= 1'b1;
      ss_lvl    <= 1'b1;
      mosi_m    <= 1'b0;
      mosi_q    <= 1'b0;
      mosi_s    <= 1'b0;
      special_m <= 1'b0;
      special_q <= 1'b0;
      special_s <= 1'b0;
      sclk_fall <= 1'b0;
      ss_fall   <= 1'b0;
      ss_rise   <= 1'b0;
    end
    else
    begin
      sclk_m    <= sclk;
      sclk_s    <= sclk_m;
      sclk_d    <= sclk_s;
      ss_m      <= ss_n;
      ss_s      <= ss_m;
      // third stage doubles as the ss_n level output
      ss_lvl    <= ss_s;
      // data pins get a third stage too, to line up with the pulses
      mosi_m    <= mosi;
      mosi_q    <= mosi_m;
      mosi_s    <= mosi_q;
      special_m <= special;
      special_q <= special_m;
      special_s <= special_q;
      // registered edge pulses, one cs cycle wide
      sclk_fall <= sclk_d & ~sclk_s;
      ss_fall   <= ss_lvl & ~ss_s;
      ss_rise   <= ~ss_lvl & ss_s;
    end
  end

endmodule

`default_nettype wire

//--- hw/frame_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_shifter #(
  parameter int FRAME_BITS = spi_reg_bridge_pkg::FRAME_BITS_DEF
) (
  input  logic                  cs,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic                  shift,
  input  logic                  din,
  output logic [FRAME_BITS-1:0] frame_word
);

  // msb first, first bit on the wire ends up in the top of the address

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      frame_word <= '0;
    end
    else if (clear)
    begin
      // start of a new frame
      frame_word <= '0;
    end
    else if (shift)
    begin
      // shift already qualified by the controller
      // so extra bits past the frame length never land here
      frame_word <= {frame_word[FRAME_BITS-2:0], din};
    end
  end

  // word holds between frames
  // reg_file reads it during the frame_valid strobe

endmodule

`default_nettype wire

//--- hw/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl #(
  parameter int FRAME_BITS = spi_reg_bridge_pkg::FRAME_BITS_DEF
) (
  input  logic cs,
  input  logic rst_n,
  input  logic ss_fall,
  input  logic ss_rise,
  input  logic sclk_fall,
  input  logic special_s,
  output logic shift_en,
  output logic clear,
  output logic frame_valid
);

  import spi_reg_bridge_pkg::*;

  // counter one bit wider than the frame length needs
  // an overlong frame saturates past FRAME_BITS instead of wrapping
  localparam int CNT_W = $clog2(FRAME_BITS + 1) + 1;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FRAME_BITS);

  frame_state_e     state;
  logic [CNT_W-1:0] bit_cnt;
  logic             err;

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      bit_cnt <= '0;
      err     <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (ss_fall)
          begin
            state   <= SHIFT;
            bit_cnt <= '0;
            err     <= 1'b0;
          end
        end
        SHIFT:
        begin
          // count every falling sclk edge, stop one past full
          if (sclk_fall && bit_cnt <= FULL_CNT)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          // sticky error, special seen or too many edges
          if (special_s || (sclk_fall && bit_cnt == FULL_CNT))
          begin
            err <= 1'b1;
          end
          if (ss_rise)
          begin
            state <= CLOSE;
          end
        end
        CLOSE:
        begin
          // single cycle to hand the verdict out
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // qualified shift pulse, ignores bits beyond the frame
  assign shift_en = (state == SHIFT) && sclk_fall && (bit_cnt < FULL_CNT);

  // shifter wipes its word as the frame opens
  assign clear = (state == IDLE) && ss_fall;

  // exact bit count and no error, strobe lasts the close cycle only
  assign frame_valid = (state == CLOSE) && (bit_cnt == FULL_CNT) && !err;

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int FRAME_BITS = spi_reg_bridge_pkg::FRAME_BITS_DEF
) (
  input  logic                                 cs,
  input  logic                                 rst_n,
  input  logic                                 frame_valid,
  input  logic [FRAME_BITS-1:0]                frame_word,
  output logic [spi_reg_bridge_pkg::DATA_W-1:0] led,
  output logic [spi_reg_bridge_pkg::DATA_W-1:0] mux_sel
);

  import spi_reg_bridge_pkg::*;

  // address is whatever sits above the data byte
  localparam int ADDR_W = FRAME_BITS - DATA_W;

  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  logic              wr_led;
  logic              wr_mux;

  // high field for the register, low byte for the value
  assign addr = frame_word[FRAME_BITS-1:DATA_W];
  assign data = frame_word[DATA_W-1:0];

  // decode
  always_comb
  begin
    wr_led = 1'b0;
    wr_mux = 1'b0;
    if (frame_valid)
    begin
      if (addr == ADDR_W'(ADDR_LED))
      begin
        wr_led = 1'b1;
      end
      else if (addr == ADDR_W'(ADDR_MUX))
      begin
        wr_mux = 1'b1;
      end
      // unknown address, both registers keep their value
    end
  end

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      led     <= '0;
      mux_sel <= '0;
    end
    else
    begin
      if (wr_led)
      begin
        led <= data;
      end
      if (wr_mux)
      begin
        mux_sel <= data;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/cs_router.sv
`timescale 1ns/1ps
`default_nettype none

module cs_router #(
  parameter int NUM_ADC_CS = spi_reg_bridge_pkg::NUM_ADC_CS_DEF
) (
  input  logic                                 cs,
  input  logic                                 rst_n,
  input  logic                                 ss_lvl,
  input  logic [spi_reg_bridge_pkg::DATA_W-1:0] mux_sel,
  output logic [NUM_ADC_CS-1:0]                adc_cs_n
);

  import spi_reg_bridge_pkg::*;

  logic [NUM_ADC_CS-1:0] cs_next;

  // mux value k picks output k-1
  // zero or out of range parks everything high
  always_comb
  begin
    cs_next = '1;
    for (int i = 0; i < NUM_ADC_CS; i++)
    begin
      if (mux_sel == DATA_W'(i + 1))
      begin
        cs_next[i] = ss_lvl;
      end
    end
  end

  // registered so the chip selects come out glitch free
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      // all adcs deselected
      adc_cs_n <= '1;
    end
    else
    begin
      adc_cs_n <= cs_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/spi_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bridge #(
  parameter int FRAME_BITS = spi_reg_bridge_pkg::FRAME_BITS_DEF,
  parameter int NUM_ADC_CS = spi_reg_bridge_pkg::NUM_ADC_CS_DEF
) (
  input  logic                                 cs,
  input  logic                                 rst_n,
  input  logic                                 sclk,
  input  logic                                 ss_n,
  input  logic                                 mosi,
  input  logic                                 special,
  output logic [spi_reg_bridge_pkg::DATA_W-1:0] led,
  output logic [spi_reg_bridge_pkg::DATA_W-1:0] mux_sel,
  output logic [NUM_ADC_CS-1:0]                adc_cs_n
);

  // synchronised pin side
  logic sclk_fall;
  logic ss_fall;
  logic ss_rise;
  logic ss_lvl;
  logic mosi_s;
  logic special_s;

  // controller to shifter and register file
  logic                  shift_en;
  logic                  clear;
  logic                  frame_valid;
  logic [FRAME_BITS-1:0] frame_word;

  spi_pin_sync u_pin_sync (
    .cs        (cs),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .special   (special),
    .sclk_fall (sclk_fall),
    .ss_fall   (ss_fall),
    .ss_rise   (ss_rise),
    .ss_lvl    (ss_lvl),
    .mosi_s    (mosi_s),
    .special_s (special_s)
  );

  frame_shifter #(
    .FRAME_BITS (FRAME_BITS)
  ) u_shifter (
    .cs         (cs),
    .rst_n      (rst_n),
    .clear      (clear),
    .shift      (shift_en),
    .din        (mosi_s),
    .frame_word (frame_word)
  );

  frame_ctrl #(
    .FRAME_BITS (FRAME_BITS)
  ) u_ctrl (
    .cs          (cs),
    .rst_n       (rst_n),
    .ss_fall     (ss_fall),
    .ss_rise     (ss_rise),
    .sclk_fall   (sclk_fall),
    .special_s   (special_s),
    .shift_en    (shift_en),
    .clear       (clear),
    .frame_valid (frame_valid)
  );

  // register bank, led at 7 and mux at 8
  reg_file #(
    .FRAME_BITS (FRAME_BITS)
  ) u_regs (
    .cs          (cs),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame_word  (frame_word),
    .led         (led),
    .mux_sel     (mux_sel)
  );

  cs_router #(
    .NUM_ADC_CS (NUM_ADC_CS)
  ) u_router (
    .cs       (cs),
    .rst_n    (rst_n),
    .ss_lvl   (ss_lvl),
    .mux_sel  (mux_sel),
    .adc_cs_n (adc_cs_n)
  );

endmodule

`default_nettype wire

//--- test/reg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module reg_checker #(
  parameter int FRAME_BITS = spi_reg_bridge_pkg::FRAME_BITS_DEF,
  parameter int NUM_ADC_CS = spi_reg_bridge_pkg::NUM_ADC_CS_DEF
) (
  input  logic                                 cs,
  input  logic                                 rst_n,
  input  logic                                 sclk,
  input  logic                                 ss_n,
  input  logic                                 mosi,
  input  logic                                 special,
  input  logic [spi_reg_bridge_pkg::DATA_W-1:0] led,
  input  logic [spi_reg_bridge_pkg::DATA_W-1:0] mux_sel,
  input  logic [NUM_ADC_CS-1:0]                adc_cs_n,
  output int                                   led_errs,
  output int                                   mux_errs,
  output int                                   adc_errs,
  output int                                   checks
);

  import spi_reg_bridge_pkg::*;

  localparam logic [31:0] ADDR_MASK = (32'd1 << (FRAME_BITS - DATA_W)) - 32'd1;

  // pin samples from the previous cs edge
  logic              sclk_q;
  logic              ss_q;
  // model of the frame on the wire
  logic [31:0]       shreg;
  int                bit_cnt;
  logic              spec_seen;
  logic [DATA_W-1:0] exp_led;
  logic [DATA_W-1:0] exp_mux;
  // cycles left until the register outputs settle
  int                pending;
  logic              check_due;
  int                ss_stable;
  int                since_rise;
  logic              reset_seen;

  // output k-1 follows ss_n for mux value k, the rest stay high
  function automatic logic [NUM_ADC_CS-1:0] route_cs(input logic lvl, input logic [7:0] sel);
    logic [NUM_ADC_CS-1:0] res;
    res = '1;
    if (int'(sel) >= 1 && int'(sel) <= NUM_ADC_CS)
    begin
      res[int'(sel) - 1] = lvl;
    end
    return res;
  endfunction

  // frame just closed, update the model if it was a good one
  task automatic close_frame();
    logic [31:0] addr;
    addr = (shreg >> DATA_W) & ADDR_MASK;
    if (bit_cnt == FRAME_BITS && !spec_seen)
    begin
      if (addr == 32'(ADDR_LED))
      begin
        exp_led = shreg[DATA_W-1:0];
      end
      else if (addr == 32'(ADDR_MUX))
      begin
        exp_mux = shreg[DATA_W-1:0];
      end
    end
  endtask

  task automatic compare_regs();
    checks++;
    if (led !== exp_led)
    begin
      led_errs++;
      $display("[FAIL] led: got 0x%02h, expected 0x%02h", led, exp_led);
    end
    if (mux_sel !== exp_mux)
    begin
      mux_errs++;
      $display("[FAIL] mux_sel: got 0x%02h, expected 0x%02h", mux_sel, exp_mux);
    end
  endtask

  task automatic compare_cs(input logic [NUM_ADC_CS-1:0] exp_cs);
    checks++;
    if (adc_cs_n !== exp_cs)
    begin
      adc_errs++;
      $display("[FAIL] adc_cs_n: got 0x%0h, expected 0x%0h", adc_cs_n, exp_cs);
    end
  endtask

  // pins change 2 ns after the edge, so sampling here is clean
  always @(posedge cs)
  begin
    if (!rst_n)
    begin
      sclk_q     = 1'b0;
      ss_q       = 1'b1;
      shreg      = '0;
      bit_cnt    = 0;
      spec_seen  = 1'b0;
      exp_led    = '0;
      exp_mux    = '0;
      pending    = 0;
      check_due  = 1'b0;
      ss_stable  = 0;
      since_rise = 0;
    end
    else
    begin
      check_due = 1'b0;
      if (pending > 0)
      begin
        pending--;
        check_due = (pending == 0);
      end
      if (since_rise < 1000)
      begin
        since_rise++;
      end
      if (ss_n != ss_q)
      begin
        ss_stable = 0;
      end
      else if (ss_stable < 1000)
      begin
        ss_stable++;
      end
      // frame opens
      if (ss_q && !ss_n)
      begin
        shreg     = '0;
        bit_cnt   = 0;
        spec_seen = 1'b0;
      end
      if (!ss_n)
      begin
        if (special)
        begin
          spec_seen = 1'b1;
        end
        // bit taken on the falling sclk edge
        if (sclk_q && !sclk)
        begin
          shreg = {shreg[30:0], mosi};
          bit_cnt++;
        end
      end
      // frame closes, registers due 5 cycles after the pin edge
      if (!ss_q && ss_n)
      begin
        close_frame();
        pending    = 4;
        since_rise = 0;
      end
      ss_q   = ss_n;
      sclk_q = sclk;
    end
  end

  // outputs compared half a cycle after the edge that moves them
  always @(negedge cs)
  begin
    if (!rst_n)
    begin
      reset_seen = 1'b0;
    end
    else
    begin
      if (!reset_seen || check_due)
      begin
        compare_regs();
      end
      if (!reset_seen)
      begin
        // all adcs deselected out of reset
        compare_cs('1);
        reset_seen = 1'b1;
      end
      else if (ss_stable >= 4 && since_rise >= 6)
      begin
        compare_cs(route_cs(ss_q, exp_mux));
      end
    end
  end

endmodule

`default_nettype wire

//--- test/spi_reg_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bridge_assertions #(
  parameter int NUM_ADC_CS = 1,
  // which block this copy watches
  parameter bit CTRL_SIDE  = 1'b1,
  parameter bit CS_SIDE    = 1'b1
) (
  input  logic                             cs,
  input  logic                             rst_n,
  input  spi_reg_bridge_pkg::frame_state_e state,
  input  logic                             shift_en,
  input  logic                             frame_valid,
  input  logic [NUM_ADC_CS-1:0]            adc_cs_n
);

  import spi_reg_bridge_pkg::*;

  // failures seen so far, read by the testbench at the end
  int fail_cnt;

  if (CTRL_SIDE)
  begin : ctrl_g
    // strobe is a single cycle, never two in a row
    strobe_one_cycle: assert property (@(posedge cs) disable iff (!rst_n)
      frame_valid |=> !frame_valid)
      else
      begin
        $error("frame_valid high for more than one cycle");
        fail_cnt++;
      end

    // no shifting while waiting for a frame
    no_shift_in_idle: assert property (@(posedge cs) disable iff (!rst_n)
      (state == IDLE) |-> !shift_en)
      else
      begin
        $error("shift_en high in IDLE");
        fail_cnt++;
      end
  end

  if (CS_SIDE)
  begin : router_g
    // at most one adc selected
    one_cs_low: assert property (@(posedge cs) disable iff (!rst_n)
      $onehot0(~adc_cs_n))
      else
      begin
        $error("more than one adc_cs_n low");
        fail_cnt++;
      end
  end

endmodule

// controller side, router ports tied off
bind frame_ctrl spi_reg_bridge_assertions #(
  .NUM_ADC_CS (1),
  .CTRL_SIDE  (1'b1),
  .CS_SIDE    (1'b0)
) ctrl_checks_i (
  .cs          (cs),
  .rst_n       (rst_n),
  .state       (state),
  .shift_en    (shift_en),
  .frame_valid (frame_valid),
  .adc_cs_n    (1'b1)
);

// router side, controller ports tied to idle
bind cs_router spi_reg_bridge_assertions #(
  .NUM_ADC_CS (NUM_ADC_CS),
  .CTRL_SIDE  (1'b0),
  .CS_SIDE    (1'b1)
) router_checks_i (
  .cs          (cs),
  .rst_n       (rst_n),
  .state       (spi_reg_bridge_pkg::IDLE),
  .shift_en    (1'b0),
  .frame_valid (1'b0),
  .adc_cs_n    (adc_cs_n)
);

`default_nettype wire

//--- test/tb_spi_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_reg_bridge;

  import spi_reg_bridge_pkg::*;

  localparam int FRAME_BITS = FRAME_BITS_DEF;
  localparam int NUM_ADC_CS = NUM_ADC_CS_DEF;
  // cs cycles per sclk phase, between frames, and after the last row
  localparam int PHASE = 4;
  localparam int GAP   = 8;
  localparam int TAIL  = 12;

  logic                  cs;
  logic                  rst_n;
  logic                  sclk;
  logic                  ss_n;
  logic                  mosi;
  logic                  special;
  logic [DATA_W-1:0]     led;
  logic [DATA_W-1:0]     mux_sel;
  logic [NUM_ADC_CS-1:0] adc_cs_n;

  int led_errs;
  int mux_errs;
  int adc_errs;
  int checks;
  int sva_fails;

  // frame table, one entry per row
  // special is the bit index where special goes high, -1 for never
  // hold keeps ss_n low that long after the frame, 0 for none
  logic [31:0] row_addr[$];
  logic [7:0]  row_data[$];
  int          row_bits[$];
  int          row_special[$];
  int          row_hold[$];
  bit          row_rand[$];

  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          cycle_limit;

  initial
  begin
    cs = 1'b0;
  end

  always #20 cs = ~cs;

  spi_reg_bridge #(
    .FRAME_BITS (FRAME_BITS),
    .NUM_ADC_CS (NUM_ADC_CS)
  ) dut_i (
    .cs       (cs),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .ss_n     (ss_n),
    .mosi     (mosi),
    .special  (special),
    .led      (led),
    .mux_sel  (mux_sel),
    .adc_cs_n (adc_cs_n)
  );

  reg_checker #(
    .FRAME_BITS (FRAME_BITS),
    .NUM_ADC_CS (NUM_ADC_CS)
  ) checker_i (
    .cs       (cs),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .ss_n     (ss_n),
    .mosi     (mosi),
    .special  (special),
    .led      (led),
    .mux_sel  (mux_sel),
    .adc_cs_n (adc_cs_n),
    .led_errs (led_errs),
    .mux_errs (mux_errs),
    .adc_errs (adc_errs),
    .checks   (checks)
  );

  // watchdog, limit set once the table is known
  always @(posedge cs)
  begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cs cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_row(input logic [31:0] addr, input logic [7:0] data, input int nbits,
                         input int special_bit, input int hold, input bit rnd);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_bits.push_back(nbits);
    row_special.push_back(special_bit);
    row_hold.push_back(hold);
    row_rand.push_back(rnd);
  endtask

  // inputs move 2 ns after the rising edge
  task automatic next_edge(input int n);
    repeat (n) @(posedge cs);
    #2;
  endtask

  task automatic send_frame(input logic [31:0] addr, input logic [7:0] data, input int nbits,
                            input int special_bit);
    logic [31:0] word;
    logic [31:0] shifted;
    word = (addr << DATA_W) | {24'd0, data};
    ss_n = 1'b0;
    next_edge(PHASE);
    for (int i = 0; i < nbits; i++)
    begin
      // msb first, bits past the frame length are zero
      if (i < FRAME_BITS)
      begin
        shifted = word >> (FRAME_BITS - 1 - i);
        mosi    = shifted[0];
      end
      else
      begin
        mosi = 1'b0;
      end
      special = (i == special_bit);
      sclk    = 1'b1;
      next_edge(PHASE);
      // falling edge, where the bridge takes mosi
      sclk = 1'b0;
      next_edge(PHASE);
    end
    special = 1'b0;
    mosi    = 1'b0;
    next_edge(PHASE);
    ss_n = 1'b1;
    next_edge(GAP);
  endtask

  // ss_n low with no clock, passes through to the selected adc
  task automatic hold_select(input int n);
    ss_n = 1'b0;
    next_edge(n);
    ss_n = 1'b1;
    next_edge(GAP);
  endtask

  initial
  begin
    int          sum;
    logic [7:0]  data;
    sclk        = 1'b0;
    ss_n        = 1'b1;
    mosi        = 1'b0;
    special     = 1'b0;
    rst_n       = 1'b0;
    lcg_state   = 32'h8b4d_5422;
    cycle_cnt   = 0;
    cycle_limit = 0;
    sum         = 0;

    // addr, data, bits, special bit, hold, random
    add_row(32'd7, 8'ha5, 16, -1, 0, 1'b0);
    add_row(32'd8, 8'h02, 16, -1, 12, 1'b0);
    add_row(32'd8, 8'h01, 16, -1, 12, 1'b0);
    add_row(32'd8, 8'h04, 16, -1, 12, 1'b0);
    add_row(32'd8, 8'h03, 16, -1, 12, 1'b0);
    add_row(32'd8, 8'h00, 16, -1, 12, 1'b0);
    add_row(32'd8, 8'h05, 16, -1, 12, 1'b0);
    add_row(32'd8, 8'h02, 16, -1, 0, 1'b0);
    // wrong bit counts
    add_row(32'd7, 8'h3c, 15, -1, 0, 1'b0);
    add_row(32'd7, 8'h3c, 17, -1, 0, 1'b0);
    add_row(32'd8, 8'h01, 15, -1, 12, 1'b0);
    // special during the frame
    add_row(32'd7, 8'h77, 16, 0, 0, 1'b0);
    add_row(32'd8, 8'h04, 16, 15, 12, 1'b0);
    add_row(32'd7, 8'h55, 16, 9, 0, 1'b0);
    // unknown addresses
    add_row(32'd9, 8'h11, 16, -1, 0, 1'b0);
    add_row(32'd6, 8'h22, 16, -1, 0, 1'b0);
    // back to back random data
    add_row(32'd7, 8'h00, 16, -1, 0, 1'b1);
    add_row(32'd8, 8'h00, 16, -1, 0, 1'b1);
    add_row(32'd7, 8'h00, 16, -1, 0, 1'b1);
    add_row(32'd8, 8'h00, 16, -1, 0, 1'b1);
    add_row(32'd7, 8'h00, 16, -1, 0, 1'b1);
    add_row(32'd8, 8'h00, 16, -1, 0, 1'b1);
    add_row(32'd7, 8'h81, 16, -1, 0, 1'b0);

    // frame plus gap, hold plus gap, doubled
    foreach (row_bits[r])
    begin
      sum += 2 * PHASE + row_bits[r] * 2 * PHASE + GAP;
      if (row_hold[r] > 0)
      begin
        sum += row_hold[r] + GAP;
      end
    end
    cycle_limit = 2 * (4 + sum + TAIL);

    next_edge(4);
    rst_n = 1'b1;
    next_edge(4);

    foreach (row_bits[r])
    begin
      data = row_data[r];
      if (row_rand[r])
      begin
        lcg_state = lcg_next(lcg_state);
        data      = lcg_state[23:16];
      end
      send_frame(row_addr[r], data, row_bits[r], row_special[r]);
      if (row_hold[r] > 0)
      begin
        hold_select(row_hold[r]);
      end
    end
    next_edge(TAIL);

    sva_fails = dut_i.u_ctrl.ctrl_checks_i.fail_cnt + dut_i.u_router.router_checks_i.fail_cnt;
    if (checks == 0)
    begin
      $display("no output checks were made");
    end
    $display("checks %0d, led errors %0d, mux_sel errors %0d, adc_cs_n errors %0d, %s %0d",
             checks, led_errs, mux_errs, adc_errs, "assertion failures", sva_fails);
    if (checks > 0 && led_errs == 0 && mux_errs == 0 && adc_errs == 0 && sva_fails == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- spi_reg_bridge.f
hw/spi_reg_bridge_pkg.sv
hw/spi_pin_sync.sv
hw/frame_shifter.sv
hw/frame_ctrl.sv
hw/reg_file.sv
hw/cs_router.sv
hw/spi_reg_bridge.sv
test/reg_checker.sv
test/spi_reg_bridge_assertions.sv
test/tb_spi_reg_bridge.sv

//--- Makefile
TOP = tb_spi_reg_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f spi_reg_bridge.f --top-module $(TOP)
	verilator --lint-only -f spi_reg_bridge.f --top-module spi_reg_bridge

sim:
	verilator --binary --timing --assert -f spi_reg_bridge.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
